//--- hdl/rv_pkg.sv
//====================
// rv32i core package
//====================
package rv_pkg;

    // widths that carry a meaning
    typedef logic [31:0] xlen_t;     // register and memory data word
    typedef logic [31:0] addr_t;     // byte address
    typedef logic [31:0] instr_t;    // raw instruction word
    typedef logic [4:0]  reg_idx_t;  // x0..x31

    // alu operation, PASS_B lets jal carry a zero operand
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        SLT,
        PASS_B
    } alu_op_e;

    // source of the register write in writeback
    typedef enum logic [1:0] {
        ALU,
        MEM,
        LINK
    } wb_sel_e;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        REG,       // value read in decode
        FROM_MEM,  // result sitting in the memory stage
        FROM_WB    // result sitting in writeback
    } fwd_sel_e;

    //====================
    // rv32i major opcodes
    localparam logic [6:0] OP_R      = 7'b0110011;  // add sub and or slt
    localparam logic [6:0] OP_I      = 7'b0010011;  // addi
    localparam logic [6:0] OP_LOAD   = 7'b0000011;  // lw
    localparam logic [6:0] OP_STORE  = 7'b0100011;  // sw
    localparam logic [6:0] OP_BRANCH = 7'b1100011;  // beq
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;  // ecall, used as halt

    localparam instr_t NOP_INSTR = 32'h0000_0013;   // addi x0,x0,0
    localparam addr_t  PC_STEP   = 32'd4;

endpackage

//--- hdl/rv_ifs.sv
`timescale 1ns/10ps
//====================
// pipeline interfaces
//====================

// decoded instruction from decode to execute, redirect comes back
interface de_if;
    import rv_pkg::*;

    logic     valid;      // low for bubbles and flushed slots
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    xlen_t    rs1_data;   // register file value incl. write-through
    xlen_t    rs2_data;
    xlen_t    imm;        // sign extended, format picked by decoder
    addr_t    pc;
    alu_op_e  alu_op;
    logic     use_imm;    // operand b is imm instead of rs2
    logic     is_branch;  // beq
    logic     is_jal;
    logic     mem_wr;     // sw
    logic     reg_wr;
    wb_sel_e  wb_sel;
    logic     halt;       // ecall marker
    logic     flush;      // taken branch or jal in execute
    addr_t    target;     // pc + imm of the redirecting instruction

    modport front (
        output valid, rs1, rs2, rd, rs1_data, rs2_data, imm, pc, alu_op,
               use_imm, is_branch, is_jal, mem_wr, reg_wr, wb_sel, halt,
        input  flush, target
    );

    modport back (
        input  valid, rs1, rs2, rd, rs1_data, rs2_data, imm, pc, alu_op,
               use_imm, is_branch, is_jal, mem_wr, reg_wr, wb_sel, halt,
        output flush, target
    );

    modport fwd (
        input rs1, rs2
    );
endinterface

// write information of the memory and writeback stages
interface wb_if;
    import rv_pkg::*;

    reg_idx_t rd_m;
    logic     reg_wr_m;
    xlen_t    alu_m;     // forwardable result in memory stage
    reg_idx_t rd_w;
    logic     reg_wr_w;
    xlen_t    data_w;    // final writeback data

    modport driver (
        output rd_m, reg_wr_m, alu_m, rd_w, reg_wr_w, data_w
    );

    modport reader (
        input rd_m, reg_wr_m, alu_m, rd_w, reg_wr_w, data_w
    );
endinterface

//--- hdl/front_end.sv
`timescale 1ns/10ps
//====================
// fetch and decode
//====================
module front_end #(
    parameter int IMEM_DEPTH = 512
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             imem_wr_en,
    input  rv_pkg::addr_t    imem_wr_addr,   // byte address
    input  rv_pkg::instr_t   imem_wr_data,
    input  rv_pkg::reg_idx_t dbg_reg_addr,
    output rv_pkg::xlen_t    dbg_reg_data,
    de_if.front              de,
    wb_if.reader             wb
);
    import rv_pkg::*;

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    // fetch
    addr_t    pc;
    instr_t   imem [IMEM_DEPTH];
    instr_t   fetch_instr;
    logic     halt_seen;    // ecall has left decode
    logic     stop;         // freeze pc, feed nops

    // if/id
    instr_t   id_instr;
    addr_t    id_pc;
    logic     id_valid;

    // decode
    instr_t   dec_instr;    // id instruction after flush
    logic     dec_valid;
    reg_idx_t rs1_d;
    reg_idx_t rs2_d;
    reg_idx_t rd_d;
    xlen_t    imm_d;
    alu_op_e  alu_op_d;
    logic     use_imm_d;
    logic     is_branch_d;
    logic     is_jal_d;
    logic     mem_wr_d;
    logic     reg_wr_d;
    wb_sel_e  wb_sel_d;
    logic     halt_d;
    xlen_t    regs [32];    // x0 never written

    // read with writeback bypass, x0 always zero
    function automatic xlen_t rf_read(input reg_idx_t idx);
        if (idx == '0) return '0;
        if (wb.reg_wr_w && (wb.rd_w == idx)) return wb.data_w;  // write-through
        return regs[idx];
    endfunction

    //====================
    // fetch stage

    // program load happens only while the core is in reset
    always_ff @(posedge clk) begin
        if (imem_wr_en && !arst_n) begin
            imem[imem_wr_addr[IMEM_AW+1:2]] <= imem_wr_data;
        end
    end

    assign stop        = halt_d || halt_seen;
    assign fetch_instr = (de.flush || stop) ? NOP_INSTR : imem[pc[IMEM_AW+1:2]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc        <= '0;
            halt_seen <= 1'b0;
        end else begin
            if (de.flush) begin
                pc <= de.target;            // redirect beats a pending halt
            end else if (!stop) begin
                pc <= pc + PC_STEP;
            end
            halt_seen <= halt_seen || halt_d;   // halt_d already masked by flush
        end
    end

    // if/id, flushed or halted slots become nop
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_instr <= NOP_INSTR;
            id_valid <= 1'b0;
        end else begin
            id_instr <= fetch_instr;
            id_valid <= !(de.flush || stop);
        end
    end

    always_ff @(posedge clk) begin
        id_pc <= pc;
    end

    //====================
    // decode stage
    assign dec_instr = de.flush ? NOP_INSTR : id_instr;
    assign dec_valid = id_valid && !de.flush;

    always_comb begin
        rs1_d       = dec_instr[19:15];
        rs2_d       = dec_instr[24:20];
        rd_d        = dec_instr[11:7];
        imm_d       = '0;
        alu_op_d    = ADD;
        use_imm_d   = 1'b0;
        is_branch_d = 1'b0;
        is_jal_d    = 1'b0;
        mem_wr_d    = 1'b0;
        reg_wr_d    = 1'b0;
        wb_sel_d    = ALU;
        halt_d      = 1'b0;
        case (dec_instr[6:0])
            OP_R: begin
                reg_wr_d = 1'b1;
                case (dec_instr[14:12])            // funct3
                    3'b000:  alu_op_d = dec_instr[30] ? SUB : ADD;
                    3'b010:  alu_op_d = SLT;
                    3'b110:  alu_op_d = OR;
                    3'b111:  alu_op_d = AND;
                    default: alu_op_d = ADD;
                endcase
            end
            OP_I, OP_LOAD: begin
                imm_d     = {{20{dec_instr[31]}}, dec_instr[31:20]};
                use_imm_d = 1'b1;
                reg_wr_d  = 1'b1;
                wb_sel_d  = (dec_instr[6:0] == OP_LOAD) ? MEM : ALU;
            end
            OP_STORE: begin
                imm_d     = {{20{dec_instr[31]}}, dec_instr[31:25], dec_instr[11:7]};
                use_imm_d = 1'b1;
                mem_wr_d  = 1'b1;
            end
            OP_BRANCH: begin
                imm_d       = {{20{dec_instr[31]}}, dec_instr[7], dec_instr[30:25],
                               dec_instr[11:8], 1'b0};
                is_branch_d = 1'b1;                // only beq kept
            end
            OP_JAL: begin
                imm_d    = {{12{dec_instr[31]}}, dec_instr[19:12], dec_instr[20],
                            dec_instr[30:21], 1'b0};
                rs1_d    = '0;                     // no sources, b reads zero
                rs2_d    = '0;
                alu_op_d = PASS_B;
                is_jal_d = 1'b1;
                reg_wr_d = 1'b1;
                wb_sel_d = LINK;
            end
            OP_SYSTEM: halt_d = 1'b1;              // ecall
            default: ;
        endcase
    end

    // register file, written at the end of writeback
    always_ff @(posedge clk) begin
        if (wb.reg_wr_w && (wb.rd_w != '0)) begin
            regs[wb.rd_w] <= wb.data_w;
        end
    end

    assign dbg_reg_data = (dbg_reg_addr == '0) ? '0 : regs[dbg_reg_addr];

    //====================
    // id/ex register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de.valid     <= 1'b0;           // bubble
            de.rs1       <= '0;
            de.rs2       <= '0;
            de.rd        <= '0;
            de.alu_op    <= ADD;
            de.use_imm   <= 1'b0;
            de.is_branch <= 1'b0;
            de.is_jal    <= 1'b0;
            de.mem_wr    <= 1'b0;
            de.reg_wr    <= 1'b0;
            de.wb_sel    <= ALU;
            de.halt      <= 1'b0;
        end else begin
            de.valid     <= dec_valid;
            de.rs1       <= rs1_d;
            de.rs2       <= rs2_d;
            de.rd        <= rd_d;
            de.alu_op    <= alu_op_d;
            de.use_imm   <= use_imm_d;
            de.is_branch <= is_branch_d;
            de.is_jal    <= is_jal_d;
            de.mem_wr    <= mem_wr_d;
            de.reg_wr    <= reg_wr_d;
            de.wb_sel    <= wb_sel_d;
            de.halt      <= halt_d;
        end
    end

    always_ff @(posedge clk) begin
        de.rs1_data <= rf_read(rs1_d);
        de.rs2_data <= rf_read(rs2_d);
        de.imm      <= imm_d;
        de.pc       <= id_pc;
    end

endmodule

//--- hdl/forward_unit.sv
`timescale 1ns/10ps
//====================
// operand forwarding
//====================
module forward_unit (
    de_if.fwd                de,
    wb_if.reader             wb,
    output rv_pkg::fwd_sel_e fwd_a,
    output rv_pkg::fwd_sel_e fwd_b
);
    import rv_pkg::*;

    logic mem_live;  // memory stage will write a real register
    logic wb_live;   // same for writeback

    // newest producer wins, so memory is checked first
    // a load in memory only has its address in alu_m, programs keep
    // one instruction between a load and its first use
    function automatic fwd_sel_e pick(input reg_idx_t rs);
        if (mem_live && (wb.rd_m == rs)) return FROM_MEM;
        if (wb_live && (wb.rd_w == rs)) return FROM_WB;
        return REG;
    endfunction

    assign mem_live = wb.reg_wr_m && (wb.rd_m != '0);
    assign wb_live  = wb.reg_wr_w && (wb.rd_w != '0);

    assign fwd_a = pick(de.rs1);
    assign fwd_b = pick(de.rs2);   // also feeds sw store data

endmodule

//--- hdl/back_end.sv
`timescale 1ns/10ps
//====================
// execute, memory, writeback
//====================
module back_end #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic             clk,
    input  logic             arst_n,
    de_if.back               de,
    wb_if.driver             wb,
    input  rv_pkg::fwd_sel_e fwd_a,
    input  rv_pkg::fwd_sel_e fwd_b,
    output logic             halt
);
    import rv_pkg::*;

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    // execute
    xlen_t    op_a;
    xlen_t    rs2_fwd;     // forwarded rs2 that is also the store data
    xlen_t    op_b;
    xlen_t    alu_res;
    logic     taken;
    addr_t    link_e;

    // memory stage
    logic     reg_wr_m;
    logic     mem_wr_m;
    logic     halt_m;
    reg_idx_t rd_m;
    wb_sel_e  wb_sel_m;
    xlen_t    res_m;
    xlen_t    store_m;
    addr_t    link_m;
    xlen_t    fwd_m;       // value other stages may take from here
    xlen_t    dmem [DMEM_DEPTH];
    xlen_t    mem_rdata;

    // writeback stage
    logic     reg_wr_w;
    logic     halt_w;
    reg_idx_t rd_w;
    wb_sel_e  wb_sel_w;
    xlen_t    res_w;
    xlen_t    mem_w;
    addr_t    link_w;
    xlen_t    data_w;

    function automatic xlen_t operand(input fwd_sel_e sel, input xlen_t reg_val);
        case (sel)
            FROM_MEM: return wb.alu_m;
            FROM_WB:  return data_w;
            default:  return reg_val;
        endcase
    endfunction

    //====================
    // execute stage
    assign op_a    = operand(fwd_a, de.rs1_data);
    assign rs2_fwd = operand(fwd_b, de.rs2_data);
    assign op_b    = de.use_imm ? de.imm : rs2_fwd;

    always_comb begin
        case (de.alu_op)
            ADD:     alu_res = op_a + op_b;
            SUB:     alu_res = op_a - op_b;
            AND:     alu_res = op_a & op_b;
            OR:      alu_res = op_a | op_b;
            SLT:     alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            PASS_B:  alu_res = op_b;
            default: alu_res = op_a + op_b;
        endcase
    end

    // beq compares the raw operands, not the alu output
    assign taken     = de.valid && (de.is_jal || (de.is_branch && (op_a == rs2_fwd)));
    assign de.flush  = taken;
    assign de.target = de.pc + de.imm;
    assign link_e    = de.pc + PC_STEP;      // jal link

    // ex/mem
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_wr_m <= 1'b0;
            mem_wr_m <= 1'b0;
            halt_m   <= 1'b0;
            rd_m     <= '0;
            wb_sel_m <= ALU;
        end else begin
            reg_wr_m <= de.valid && de.reg_wr;
            mem_wr_m <= de.valid && de.mem_wr;
            halt_m   <= de.valid && de.halt;
            rd_m     <= de.rd;
            wb_sel_m <= de.wb_sel;
        end
    end

    always_ff @(posedge clk) begin
        res_m   <= alu_res;
        store_m <= rs2_fwd;
        link_m  <= link_e;
    end

    //====================
    // memory stage with data memory word addressed by result upper bits
    always_ff @(posedge clk) begin
        if (mem_wr_m) begin
            dmem[res_m[DMEM_AW+1:2]] <= store_m;
        end
    end

    assign mem_rdata = dmem[res_m[DMEM_AW+1:2]];        // async read
    assign fwd_m     = (wb_sel_m == LINK) ? link_m : res_m;

    // mem/wb
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_wr_w <= 1'b0;
            halt_w   <= 1'b0;
            rd_w     <= '0;
            wb_sel_w <= ALU;
        end else begin
            reg_wr_w <= reg_wr_m;
            halt_w   <= halt_w || halt_m;     // sticky until reset
            rd_w     <= rd_m;
            wb_sel_w <= wb_sel_m;
        end
    end

    always_ff @(posedge clk) begin
        res_w  <= res_m;
        mem_w  <= mem_rdata;
        link_w <= link_m;
    end

    //====================
    // writeback mux
    always_comb begin
        case (wb_sel_w)
            MEM:     data_w = mem_w;
            LINK:    data_w = link_w;
            default: data_w = res_w;
        endcase
    end

    assign halt = halt_w;

    assign wb.rd_m     = rd_m;
    assign wb.reg_wr_m = reg_wr_m;
    assign wb.alu_m    = fwd_m;
    assign wb.rd_w     = rd_w;
    assign wb.reg_wr_w = reg_wr_w;
    assign wb.data_w   = data_w;

endmodule

//--- hdl/rv_core_top.sv
`timescale 1ns/10ps
//====================
// rv32i core top
//====================
module rv_core_top #(
    parameter int IMEM_DEPTH = 512,   // instruction words
    parameter int DMEM_DEPTH = 64     // data words
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             imem_wr_en,     // honoured only in reset
    input  rv_pkg::addr_t    imem_wr_addr,
    input  rv_pkg::instr_t   imem_wr_data,
    input  rv_pkg::reg_idx_t dbg_reg_addr,
    output rv_pkg::xlen_t    dbg_reg_data,
    output logic             halt
);
    import rv_pkg::*;

    fwd_sel_e fwd_a;   // operand sources for execute
    fwd_sel_e fwd_b;

    de_if de_bus ();
    wb_if wb_bus ();

    // fetch, decode, register file
    front_end #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_front_end (
        .clk          (clk),
        .arst_n       (arst_n),
        .imem_wr_en   (imem_wr_en),
        .imem_wr_addr (imem_wr_addr),
        .imem_wr_data (imem_wr_data),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data),
        .de           (de_bus.front),
        .wb           (wb_bus.reader)
    );

    forward_unit u_forward_unit (
        .de    (de_bus.fwd),
        .wb    (wb_bus.reader),
        .fwd_a (fwd_a),
        .fwd_b (fwd_b)
    );

    // execute, data memory, writeback
    back_end #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_back_end (
        .clk    (clk),
        .arst_n (arst_n),
        .de     (de_bus.back),
        .wb     (wb_bus.driver),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b),
        .halt   (halt)
    );

endmodule

//--- dv/rv_core_properties.sv
`timescale 1ns/10ps
//====================
// core assertions
//====================
module rv_core_properties (
    input logic             clk,
    input logic             arst_n,
    input logic             halt,
    input logic             flush,         // taken redirect from execute
    input rv_pkg::reg_idx_t dbg_reg_addr,
    input rv_pkg::xlen_t    dbg_reg_data
);

    //====================
    // halt stays up until the next reset
    property halt_sticky;
        @(posedge clk) disable iff (!arst_n)
            halt |=> halt;
    endproperty

    // debug port, x0 is hardwired
    property dbg_x0_zero;
        @(posedge clk)
            (dbg_reg_addr == '0) |-> (dbg_reg_data == '0);
    endproperty

    // no redirect while the pipeline is held in reset
    property no_flush_in_reset;
        @(posedge clk)
            !arst_n |-> !flush;
    endproperty

    a_halt_sticky: assert property (halt_sticky)
        else $error("halt dropped while reset inactive");
    a_dbg_x0_zero: assert property (dbg_x0_zero)
        else $error("debug read of x0 not zero");
    a_no_flush_in_reset: assert property (no_flush_in_reset)
        else $error("flush high during reset");

endmodule

bind rv_core_top rv_core_properties u_properties (
    .clk          (clk),
    .arst_n       (arst_n),
    .halt         (halt),
    .flush        (de_bus.flush),
    .dbg_reg_addr (dbg_reg_addr),
    .dbg_reg_data (dbg_reg_data)
);

//--- dv/tb_rv_core.sv
`timescale 1ns/10ps
//====================
// rv32i core testbench
//====================
module tb_rv_core;
    import rv_pkg::*;

    localparam int IMEM_WORDS  = 512;
    localparam int DMEM_WORDS  = 64;
    localparam int RUN_TIMEOUT = 300;    // cycles from reset release to halt

    logic        clk;
    logic        arst_n;
    logic        imem_wr_en;
    addr_t       imem_wr_addr;
    instr_t      imem_wr_data;
    reg_idx_t    dbg_reg_addr;
    xlen_t       dbg_reg_data;
    logic        halt;

    int          errors;
    int          checks;
    int          tests;
    logic [31:0] rng;                    // xorshift state

    instr_t      prog [$];               // program being assembled
    xlen_t       model_rf [32];          // in-order register model
    logic        wrote [32];             // registers the program sets
    xlen_t       model_dm [DMEM_WORDS];

    rv_core_top #(
        .IMEM_DEPTH (IMEM_WORDS),
        .DMEM_DEPTH (DMEM_WORDS)
    ) dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .imem_wr_en   (imem_wr_en),
        .imem_wr_addr (imem_wr_addr),
        .imem_wr_data (imem_wr_data),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data),
        .halt         (halt)
    );

    always #4 clk = ~clk;                // 8 ns period

    //====================
    // random values and the reference model
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [11:0] rand_imm();
        rng = xorshift32(rng);
        return rng[11:0];
    endfunction

    function automatic xlen_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    task automatic clear_program();
        prog.delete();
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
            wrote[i]    = 1'b0;
        end
    endtask

    task automatic set_model(input reg_idx_t rd, input xlen_t val);
        if (rd != 5'd0) begin            // x0 stays zero
            model_rf[rd] = val;
            wrote[rd]    = 1'b1;
        end
    endtask

    //====================
    // each assembler call adds one instruction and steps the model
    task automatic addi_instr(input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
        prog.push_back({imm, rs1, 3'b000, rd, OP_I});
        set_model(rd, model_rf[rs1] + sext12(imm));
    endtask

    // on a path the program skips so the model stays untouched
    task automatic dead_instr(input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
        prog.push_back({imm, rs1, 3'b000, rd, OP_I});
    endtask

    task automatic rtype_instr(input alu_op_e op, input reg_idx_t rd, input reg_idx_t rs1,
                               input reg_idx_t rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        xlen_t      a;
        xlen_t      b;
        xlen_t      res;
        a  = model_rf[rs1];
        b  = model_rf[rs2];
        f7 = (op == SUB) ? 7'b0100000 : 7'b0000000;
        case (op)
            AND:     f3 = 3'b111;
            OR:      f3 = 3'b110;
            SLT:     f3 = 3'b010;
            default: f3 = 3'b000;        // add and sub
        endcase
        case (op)
            SUB:     res = a - b;
            AND:     res = a & b;
            OR:      res = a | b;
            SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: res = a + b;
        endcase
        prog.push_back({f7, rs2, rs1, f3, rd, OP_R});
        set_model(rd, res);
    endtask

    task automatic store_instr(input reg_idx_t rs2, input reg_idx_t rs1, input logic [11:0] imm);
        xlen_t addr;
        addr = model_rf[rs1] + sext12(imm);
        model_dm[addr[7:2]] = model_rf[rs2];   // word index
        prog.push_back({imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE});
    endtask

    task automatic load_instr(input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
        xlen_t addr;
        addr = model_rf[rs1] + sext12(imm);
        prog.push_back({imm, rs1, 3'b010, rd, OP_LOAD});
        set_model(rd, model_dm[addr[7:2]]);
    endtask

    task automatic beq_instr(input reg_idx_t rs1, input reg_idx_t rs2, input logic [12:0] off);
        prog.push_back({off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OP_BRANCH});
    endtask

    task automatic jal_instr(input reg_idx_t rd, input logic [20:0] off);
        xlen_t link;
        link = xlen_t'(prog.size() * 4 + 4);   // pc of this jal plus 4
        prog.push_back({off[20], off[10:1], off[11], off[19:12], rd, OP_JAL});
        set_model(rd, link);
    endtask

    task automatic ecall_instr();
        prog.push_back(32'h0000_0073);
    endtask

    //====================
    // compare tasks
    task automatic check_reg(input reg_idx_t idx, input xlen_t exp);
        @(negedge clk);
        dbg_reg_addr = idx;
        #2;                              // combinational read settles
        checks++;
        if (dbg_reg_data !== exp) begin
            errors++;
            $display("[FAIL] %t: x%0d reads %h, expected %h", $time, idx, dbg_reg_data, exp);
        end
    endtask

    task automatic check_halt(input logic exp);
        checks++;
        if (halt !== exp) begin
            errors++;
            $display("[FAIL] %t: halt is %b, expected %b", $time, halt, exp);
        end
    endtask

    task automatic compare_registers();
        for (int i = 1; i < 32; i++) begin
            if (wrote[i]) check_reg(reg_idx_t'(i), model_rf[i]);
        end
    endtask

    //====================
    // program load and run
    task automatic load_program();
        @(negedge clk);
        arst_n = 1'b0;
        repeat (3) @(negedge clk);
        check_halt(1'b0);
        for (int i = 0; i < IMEM_WORDS; i++) begin   // rest of memory gets nops
            imem_wr_en   = 1'b1;
            imem_wr_addr = addr_t'(i * 4);
            imem_wr_data = (i < prog.size()) ? prog[i] : NOP_INSTR;
            @(negedge clk);
        end
        imem_wr_en = 1'b0;
    endtask

    task automatic run_program();
        int n;
        arst_n = 1'b1;
        @(negedge clk);
        check_halt(1'b0);                // just out of reset
        n = 0;
        while (!halt && (n < RUN_TIMEOUT)) begin
            @(negedge clk);
            n++;
        end
        if (!halt) begin
            errors++;
            $display("timeout at %t: halt did not rise within %0d cycles", $time, RUN_TIMEOUT);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "errors found");
    endtask

    //====================
    // directed tests
    task automatic alu_ops();
        int e0;
        e0 = errors;
        clear_program();
        for (int r = 1; r <= 10; r++) begin
            addi_instr(reg_idx_t'(r), 5'd0, rand_imm());
        end
        rtype_instr(ADD, 5'd11, 5'd1, 5'd2);
        rtype_instr(SUB, 5'd12, 5'd3, 5'd4);
        rtype_instr(AND, 5'd13, 5'd5, 5'd6);
        rtype_instr(OR,  5'd14, 5'd7, 5'd8);
        rtype_instr(SLT, 5'd15, 5'd9, 5'd10);
        rtype_instr(SLT, 5'd16, 5'd10, 5'd9);
        rtype_instr(SUB, 5'd17, 5'd0, 5'd1);     // negate
        ecall_instr();
        load_program();
        run_program();
        compare_registers();
        report_test("alu_ops", e0);
    endtask

    task automatic forwarding_chains();
        int e0;
        e0 = errors;
        clear_program();
        addi_instr(5'd1, 5'd0, rand_imm());
        addi_instr(5'd2, 5'd1, rand_imm());      // distance 1 from the memory stage
        addi_instr(5'd5, 5'd0, rand_imm());
        rtype_instr(ADD, 5'd3, 5'd2, 5'd1);      // x2 from writeback and x1 via write-through
        addi_instr(5'd6, 5'd0, rand_imm());
        addi_instr(5'd7, 5'd0, rand_imm());
        rtype_instr(SUB, 5'd4, 5'd3, 5'd6);      // distance 3 and 2
        rtype_instr(OR,  5'd8, 5'd4, 5'd7);
        addi_instr(5'd0, 5'd8, 12'd5);           // dropped write to x0
        rtype_instr(ADD, 5'd9, 5'd0, 5'd8);      // x0 must not forward from memory
        rtype_instr(OR,  5'd11, 5'd0, 5'd9);     // nor from writeback
        rtype_instr(ADD, 5'd12, 5'd0, 5'd0);     // nor through the write-through
        rtype_instr(SLT, 5'd10, 5'd9, 5'd4);
        ecall_instr();
        load_program();
        run_program();
        compare_registers();
        report_test("forwarding_chains", e0);
    endtask

    task automatic store_load();
        int e0;
        e0 = errors;
        clear_program();
        addi_instr(5'd1, 5'd0, rand_imm());
        addi_instr(5'd2, 5'd0, rand_imm());
        addi_instr(5'd3, 5'd0, rand_imm());
        addi_instr(5'd10, 5'd0, 12'd16);         // base address
        store_instr(5'd1, 5'd10, 12'd0);         // base forwarded from memory stage
        store_instr(5'd2, 5'd10, 12'd4);
        addi_instr(5'd4, 5'd3, 12'd1);
        store_instr(5'd4, 5'd10, 12'd12);        // store data forwarded
        store_instr(5'd3, 5'd10, 12'hff8);       // negative offset
        load_instr(5'd11, 5'd10, 12'd0);
        addi_instr(5'd20, 5'd0, 12'd1);          // spacer after each load
        load_instr(5'd12, 5'd10, 12'd4);
        addi_instr(5'd21, 5'd0, 12'd2);
        rtype_instr(ADD, 5'd15, 5'd12, 5'd11);   // load data from writeback
        load_instr(5'd13, 5'd10, 12'd12);
        addi_instr(5'd22, 5'd0, 12'd3);
        load_instr(5'd14, 5'd10, 12'hff8);
        addi_instr(5'd23, 5'd0, 12'd4);
        ecall_instr();
        load_program();
        run_program();
        compare_registers();
        report_test("store_load", e0);
    endtask

    task automatic control_flow();
        int e0;
        e0 = errors;
        clear_program();
        addi_instr(5'd1, 5'd0, 12'd7);           // 0x00
        addi_instr(5'd2, 5'd0, 12'd7);
        addi_instr(5'd3, 5'd0, 12'd9);
        addi_instr(5'd5, 5'd0, 12'h011);         // sentinel registers
        addi_instr(5'd6, 5'd0, 12'h022);
        beq_instr(5'd1, 5'd2, 13'd12);           // 0x14 taken to 0x20
        dead_instr(5'd5, 5'd0, 12'hfff);
        dead_instr(5'd6, 5'd0, 12'hfff);
        addi_instr(5'd7, 5'd0, 12'd1);           // taken marker
        beq_instr(5'd1, 5'd3, 13'd8);            // 0x24 not taken
        addi_instr(5'd8, 5'd0, 12'd2);           // fall-through marker
        jal_instr(5'd9, 21'd12);                 // 0x2c jumps to 0x38
        dead_instr(5'd5, 5'd0, 12'hffe);
        dead_instr(5'd6, 5'd0, 12'hffe);
        rtype_instr(ADD, 5'd11, 5'd9, 5'd0);     // link value forwarded
        ecall_instr();
        load_program();
        run_program();
        compare_registers();
        report_test("control_flow", e0);
    endtask

    task automatic halt_behavior();
        int e0;
        e0 = errors;
        clear_program();
        addi_instr(5'd1, 5'd0, rand_imm());
        addi_instr(5'd2, 5'd1, rand_imm());
        addi_instr(5'd3, 5'd0, rand_imm());
        ecall_instr();
        dead_instr(5'd1, 5'd0, 12'h055);         // must never retire
        dead_instr(5'd3, 5'd0, 12'h066);
        load_program();
        run_program();
        repeat (20) begin
            @(negedge clk);
            check_halt(1'b1);
        end
        compare_registers();
        @(negedge clk);
        arst_n = 1'b0;
        #1;
        check_halt(1'b0);                        // async clear
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_halt(1'b0);
        report_test("halt_behavior", e0);
    endtask

    //====================
    // main sequence
    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk          = 1'b0;
        arst_n       = 1'b0;
        imem_wr_en   = 1'b0;
        imem_wr_addr = '0;
        imem_wr_data = '0;
        dbg_reg_addr = '0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        rng          = 32'h5ebe_082b;
        alu_ops();
        forwarding_chains();
        store_load();
        control_flow();
        halt_behavior();
        $display("tests %0d, checks %0d, failures %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
hdl/rv_pkg.sv
hdl/rv_ifs.sv
hdl/front_end.sv
hdl/forward_unit.sv
hdl/back_end.sv
hdl/rv_core_top.sv
dv/rv_core_properties.sv
dv/tb_rv_core.sv

//--- Makefile
# verilator build and run of the rv32i core testbench

.PHONY: help test clean

help:
	@echo "make test   build with verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_rv_core \
		-f filelist.f -Mdir obj_dir -o tb_rv_core
	-./obj_dir/tb_rv_core > sim.log 2>&1
	cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
